/* axil_read_pack.sv */
// combinational; offset must be aligned to size, and an 8-byte size returns the whole word twice
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defs.svh"

module axil_read_pack (
  input  wire [`BR_AXIL_DATA_W-1:0]     data_i,
  input  wire [1:0]                     offset_i,
  input  wire bedrock_pkg::msg_size_e   size_i,
  output logic [`BR_IO_DATA_W-1:0]      data_o
);

  logic [`BR_AXIL_DATA_W-1:0] shifted;

  // addressed byte moves down to bit 0
  assign shifted = data_i >> {offset_i, 3'b000};

  always_comb begin
    case (size_i)
      bedrock_pkg::e_size_1: data_o = {(`BR_IO_DATA_W/8){shifted[7:0]}};
      bedrock_pkg::e_size_2: data_o = {(`BR_IO_DATA_W/16){shifted[15:0]}};
      default:               data_o = {(`BR_IO_DATA_W/`BR_AXIL_DATA_W){shifted}};
    endcase
  end

  // a misaligned field would run past the top of the word
  always_comb begin
    a_offset_aligned: assert final ($isunknown({offset_i, size_i})
                                    || (size_i == bedrock_pkg::e_size_1)
                                    || (size_i == bedrock_pkg::e_size_2 && !offset_i[0])
                                    || (offset_i == 2'b00))
      else $error("read offset %0d not aligned to size %0d", offset_i, size_i);
  end

endmodule

`default_nettype wire

/* axil_reg_target.sv */
// always answers OKAY; address bits 5:2 pick the register so the space aliases every 64 bytes
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defs.svh"

module axil_reg_target (
  input  wire                              clk_i,
  input  wire                              reset_i,

  input  wire [`BR_ADDR_W-1:0]             s_axil_awaddr_i,
  input  wire bedrock_pkg::axi_prot_e      s_axil_awprot_i,
  input  wire                              s_axil_awvalid_i,
  output logic                             s_axil_awready_o,

  input  wire [`BR_AXIL_DATA_W-1:0]        s_axil_wdata_i,
  input  wire [`BR_AXIL_DATA_W/8-1:0]      s_axil_wstrb_i,
  input  wire                              s_axil_wvalid_i,
  output logic                             s_axil_wready_o,

  output bedrock_pkg::axi_resp_e           s_axil_bresp_o,
  output logic                             s_axil_bvalid_o,
  input  wire                              s_axil_bready_i,

  input  wire [`BR_ADDR_W-1:0]             s_axil_araddr_i,
  input  wire bedrock_pkg::axi_prot_e      s_axil_arprot_i,
  input  wire                              s_axil_arvalid_i,
  output logic                             s_axil_arready_o,

  output logic [`BR_AXIL_DATA_W-1:0]       s_axil_rdata_o,
  output bedrock_pkg::axi_resp_e           s_axil_rresp_o,
  output logic                             s_axil_rvalid_o,
  input  wire                              s_axil_rready_i
);

  localparam int strb_width_lp = `BR_AXIL_DATA_W / 8;
  localparam int idx_width_lp  = $clog2(`BR_REG_COUNT);

  logic [`BR_AXIL_DATA_W-1:0] regs_r [`BR_REG_COUNT];

  logic                       aw_held_r, w_held_r;
  logic [idx_width_lp-1:0]    widx_r;
  logic [`BR_AXIL_DATA_W-1:0] wdata_r;
  logic [strb_width_lp-1:0]   wstrb_r;
  logic                       do_write;

  assign s_axil_awready_o = ~aw_held_r;
  assign s_axil_wready_o  = ~w_held_r;
  assign s_axil_arready_o = ~s_axil_rvalid_o;
  assign s_axil_bresp_o   = bedrock_pkg::e_resp_okay;
  assign s_axil_rresp_o   = bedrock_pkg::e_resp_okay;

  // both halves present and no response waiting yet
  assign do_write = aw_held_r & w_held_r & ~s_axil_bvalid_o;

  always_ff @(posedge clk_i) begin
    if (s_axil_awvalid_i && s_axil_awready_o) begin
      widx_r <= s_axil_awaddr_i[2 +: idx_width_lp];
    end
    if (s_axil_wvalid_i && s_axil_wready_o) begin
      wdata_r <= s_axil_wdata_i;
      wstrb_r <= s_axil_wstrb_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_held_r       <= 1'b0;
      w_held_r        <= 1'b0;
      s_axil_bvalid_o <= 1'b0;
    end else begin
      if (s_axil_awvalid_i && s_axil_awready_o) begin
        aw_held_r <= 1'b1;
      end
      if (s_axil_wvalid_i && s_axil_wready_o) begin
        w_held_r <= 1'b1;
      end
      if (do_write) begin
        s_axil_bvalid_o <= 1'b1;
      end
      // response accepted, both holding slots free again
      if (s_axil_bvalid_o && s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;
        aw_held_r       <= 1'b0;
        w_held_r        <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `BR_REG_COUNT; i++) begin
        regs_r[i] <= '0;
      end
    end else if (do_write) begin
      for (int b = 0; b < strb_width_lp; b++) begin
        if (wstrb_r[b]) begin
          regs_r[widx_r][8*b +: 8] <= wdata_r[8*b +: 8];
        end
      end
    end
  end

  // read data captured at the ar transfer
  always_ff @(posedge clk_i) begin
    if (s_axil_arvalid_i && s_axil_arready_o) begin
      s_axil_rdata_o <= regs_r[s_axil_araddr_i[2 +: idx_width_lp]];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s_axil_rvalid_o <= 1'b0;
    end else if (s_axil_arvalid_i && s_axil_arready_o) begin
      s_axil_rvalid_o <= 1'b1;
    end else if (s_axil_rready_i) begin
      s_axil_rvalid_o <= 1'b0;
    end
  end

  // manager holds each request and its payload until taken
  a_aw_held: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_awvalid_i && !s_axil_awready_o |=> s_axil_awvalid_i && $stable(s_axil_awaddr_i))
    else $error("write address valid dropped before ready");

  a_w_held: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_wvalid_i && !s_axil_wready_o
      |=> s_axil_wvalid_i && $stable({s_axil_wdata_i, s_axil_wstrb_i}))
    else $error("write data valid dropped before ready");

  a_ar_held: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_arvalid_i && !s_axil_arready_o |=> s_axil_arvalid_i && $stable(s_axil_araddr_i))
    else $error("read address valid dropped before ready");

  a_prot_fixed: assert property (@(posedge clk_i) disable iff (reset_i)
    (!s_axil_awvalid_i || s_axil_awprot_i == bedrock_pkg::e_prot_dsn)
    && (!s_axil_arvalid_i || s_axil_arprot_i == bedrock_pkg::e_prot_dsn))
    else $error("unexpected protection attributes");

endmodule

`default_nettype wire

/* bedrock_pkg.sv */
// shared BedRock and AXI4-Lite types; 8-byte size exists in the encoding but is not supported
`default_nettype none

`include "bridge_defs.svh"

package bedrock_pkg;

  typedef enum logic [1:0] {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_msg_e;

  // log2 of the access size in bytes
  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } msg_size_e;

  typedef struct packed {
    mem_msg_e               msg_type;
    msg_size_e              size;
    logic [`BR_ADDR_W-1:0]  addr;
    // requester tag, echoed back untouched
    logic [7:0]             tag;
  } mem_header_s;

  typedef enum logic [1:0] {
    e_resp_okay   = 2'b00,
    e_resp_exokay = 2'b01,
    e_resp_slverr = 2'b10,
    e_resp_decerr = 2'b11
  } axi_resp_e;

  // privileged, non-secure and instruction bits
  typedef enum logic [2:0] {
    e_prot_dsn = 3'b000,
    e_prot_dpn = 3'b001,
    e_prot_dnn = 3'b010,
    e_prot_isn = 3'b100
  } axi_prot_e;

endpackage

`default_nettype wire

/* bridge_defs.svh */
// widths for a 32-bit AXI4-Lite path under a 64-bit BedRock I/O bus; register count must be a power of two
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// physical address width carried in the command header
`define BR_ADDR_W 32

// AXI4-Lite data width, only 32 is supported by the strobe logic
`define BR_AXIL_DATA_W 32

// BedRock I/O data width, read fields are replicated up to this
`define BR_IO_DATA_W 64

// registers in the AXI4-Lite target, higher addresses alias
`define BR_REG_COUNT 16

`endif

/* burst_to_axil.sv */
// one transaction in flight; single-beat commands of 1, 2 or 4 bytes; write data taken from the low 32 bits
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defs.svh"

module burst_to_axil (
  input  wire                              clk_i,
  input  wire                              reset_i,

  input  wire bedrock_pkg::mem_header_s    io_cmd_header_i,
  input  wire                              io_cmd_header_v_i,
  input  wire                              io_cmd_has_data_i,
  output logic                             io_cmd_header_ready_and_o,
  input  wire [`BR_IO_DATA_W-1:0]          io_cmd_data_i,
  input  wire                              io_cmd_data_v_i,
  input  wire                              io_cmd_last_i,
  output logic                             io_cmd_data_ready_and_o,

  output bedrock_pkg::mem_header_s         io_resp_header_o,
  output logic                             io_resp_header_v_o,
  output logic                             io_resp_has_data_o,
  input  wire                              io_resp_header_ready_and_i,
  output logic [`BR_IO_DATA_W-1:0]         io_resp_data_o,
  output logic                             io_resp_data_v_o,
  output logic                             io_resp_last_o,
  input  wire                              io_resp_data_ready_and_i,

  output logic [`BR_ADDR_W-1:0]            m_axil_awaddr_o,
  output bedrock_pkg::axi_prot_e           m_axil_awprot_o,
  output logic                             m_axil_awvalid_o,
  input  wire                              m_axil_awready_i,

  output logic [`BR_AXIL_DATA_W-1:0]       m_axil_wdata_o,
  output logic [`BR_AXIL_DATA_W/8-1:0]     m_axil_wstrb_o,
  output logic                             m_axil_wvalid_o,
  input  wire                              m_axil_wready_i,

  input  wire bedrock_pkg::axi_resp_e      m_axil_bresp_i,
  input  wire                              m_axil_bvalid_i,
  output logic                             m_axil_bready_o,

  output logic [`BR_ADDR_W-1:0]            m_axil_araddr_o,
  output bedrock_pkg::axi_prot_e           m_axil_arprot_o,
  output logic                             m_axil_arvalid_o,
  input  wire                              m_axil_arready_i,

  input  wire [`BR_AXIL_DATA_W-1:0]        m_axil_rdata_i,
  input  wire bedrock_pkg::axi_resp_e      m_axil_rresp_i,
  input  wire                              m_axil_rvalid_i,
  output logic                             m_axil_rready_o
);

  localparam int strb_width_lp = `BR_AXIL_DATA_W / 8;

  typedef enum logic [2:0] {
    e_ready,
    e_write_addr_data,
    e_write_addr,
    e_write_data,
    e_write_resp,
    e_read_addr,
    e_read_header,
    e_read_data
  } state_e;

  state_e                    state_r, state_n;
  bedrock_pkg::mem_header_s  hdr_r;
  logic                      has_data_r;
  logic [strb_width_lp-1:0]  strb_mask;

  // header buffer, loaded on the command header transfer
  always_ff @(posedge clk_i) begin
    if (io_cmd_header_v_i && io_cmd_header_ready_and_o) begin
      hdr_r      <= io_cmd_header_i;
      has_data_r <= io_cmd_has_data_i;
    end
  end

  always_comb begin
    case (hdr_r.size)
      bedrock_pkg::e_size_1: strb_mask = strb_width_lp'(4'h1);
      bedrock_pkg::e_size_2: strb_mask = strb_width_lp'(4'h3);
      default:               strb_mask = strb_width_lp'(4'hF);
    endcase
  end

  // fixed payload fields, qualified by the valids below
  assign m_axil_awaddr_o    = hdr_r.addr;
  assign m_axil_araddr_o    = hdr_r.addr;
  assign m_axil_awprot_o    = bedrock_pkg::e_prot_dsn;
  assign m_axil_arprot_o    = bedrock_pkg::e_prot_dsn;
  assign m_axil_wdata_o     = io_cmd_data_i[`BR_AXIL_DATA_W-1:0];
  assign m_axil_wstrb_o     = strb_mask << hdr_r.addr[1:0];
  assign io_resp_header_o   = hdr_r;
  assign io_resp_has_data_o = ~has_data_r;
  assign io_resp_last_o     = 1'b1;

  axil_read_pack read_pack_i (
    .data_i   (m_axil_rdata_i),
    .offset_i (hdr_r.addr[1:0]),
    .size_i   (hdr_r.size),
    .data_o   (io_resp_data_o)
  );

  always_comb begin
    state_n                   = state_r;
    io_cmd_header_ready_and_o = 1'b0;
    io_cmd_data_ready_and_o   = 1'b0;
    io_resp_header_v_o        = 1'b0;
    io_resp_data_v_o          = 1'b0;
    m_axil_awvalid_o          = 1'b0;
    m_axil_wvalid_o           = 1'b0;
    m_axil_bready_o           = 1'b0;
    m_axil_arvalid_o          = 1'b0;
    m_axil_rready_o           = 1'b0;

    case (state_r)
      e_ready: begin
        io_cmd_header_ready_and_o = 1'b1;
        if (io_cmd_header_v_i) begin
          state_n = io_cmd_has_data_i ? e_write_addr_data : e_read_addr;
        end
      end
      // aw and w complete on their own edges
      e_write_addr_data: begin
        m_axil_awvalid_o        = 1'b1;
        m_axil_wvalid_o         = io_cmd_data_v_i;
        io_cmd_data_ready_and_o = m_axil_wready_i;
        if (m_axil_awready_i && m_axil_wvalid_o && m_axil_wready_i) begin
          state_n = e_write_resp;
        end else if (m_axil_awready_i) begin
          state_n = e_write_data;
        end else if (m_axil_wvalid_o && m_axil_wready_i) begin
          state_n = e_write_addr;
        end
      end
      e_write_addr: begin
        m_axil_awvalid_o = 1'b1;
        if (m_axil_awready_i) begin
          state_n = e_write_resp;
        end
      end
      e_write_data: begin
        m_axil_wvalid_o         = io_cmd_data_v_i;
        io_cmd_data_ready_and_o = m_axil_wready_i;
        if (m_axil_wvalid_o && m_axil_wready_i) begin
          state_n = e_write_resp;
        end
      end
      // b and the response header move on the same edge
      e_write_resp: begin
        io_resp_header_v_o = m_axil_bvalid_i;
        m_axil_bready_o    = io_resp_header_ready_and_i;
        if (m_axil_bvalid_i && io_resp_header_ready_and_i) begin
          state_n = e_ready;
        end
      end
      e_read_addr: begin
        m_axil_arvalid_o = 1'b1;
        if (m_axil_arready_i) begin
          state_n = e_read_header;
        end
      end
      e_read_header: begin
        io_resp_header_v_o = 1'b1;
        if (io_resp_header_ready_and_i) begin
          state_n = e_read_data;
        end
      end
      // r and the response data move on the same edge
      e_read_data: begin
        io_resp_data_v_o = m_axil_rvalid_i;
        m_axil_rready_o  = io_resp_data_ready_and_i;
        if (m_axil_rvalid_i && io_resp_data_ready_and_i) begin
          state_n = e_ready;
        end
      end
      default: state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_ready;
    end else begin
      state_r <= state_n;
    end
  end

  a_resp_okay: assert property (@(posedge clk_i) disable iff (reset_i)
    (!m_axil_bvalid_i || m_axil_bresp_i == bedrock_pkg::e_resp_okay)
    && (!m_axil_rvalid_i || m_axil_rresp_i == bedrock_pkg::e_resp_okay))
    else $error("target returned a non-OKAY response");

  a_type_has_data: assert property (@(posedge clk_i) disable iff (reset_i)
    io_cmd_header_v_i |-> (io_cmd_has_data_i == (io_cmd_header_i.msg_type inside
      {bedrock_pkg::e_mem_wr, bedrock_pkg::e_mem_uc_wr})))
    else $error("command type and has_data disagree");

  a_size_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    io_cmd_header_v_i |-> io_cmd_header_i.size != bedrock_pkg::e_size_8)
    else $error("8-byte command not supported on a 32-bit AXI4-Lite port");

  a_single_beat: assert property (@(posedge clk_i) disable iff (reset_i)
    io_cmd_data_v_i |-> io_cmd_last_i)
    else $error("command data must be a single beat");

endmodule

`default_nettype wire

/* io_axil_top.f */
+incdir+.
bedrock_pkg.sv
axil_read_pack.sv
burst_to_axil.sv
axil_reg_target.sv
io_axil_top.sv
tb_io_axil_top.sv

/* io_axil_top.sv */
// bridge and register target joined by an internal AXI4-Lite link; only BedRock ports are exposed
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defs.svh"

module io_axil_top (
  input  wire                              clk_i,
  input  wire                              reset_i,

  input  wire bedrock_pkg::mem_header_s    io_cmd_header_i,
  input  wire                              io_cmd_header_v_i,
  input  wire                              io_cmd_has_data_i,
  output logic                             io_cmd_header_ready_and_o,
  input  wire [`BR_IO_DATA_W-1:0]          io_cmd_data_i,
  input  wire                              io_cmd_data_v_i,
  input  wire                              io_cmd_last_i,
  output logic                             io_cmd_data_ready_and_o,

  output bedrock_pkg::mem_header_s         io_resp_header_o,
  output logic                             io_resp_header_v_o,
  output logic                             io_resp_has_data_o,
  input  wire                              io_resp_header_ready_and_i,
  output logic [`BR_IO_DATA_W-1:0]         io_resp_data_o,
  output logic                             io_resp_data_v_o,
  output logic                             io_resp_last_o,
  input  wire                              io_resp_data_ready_and_i
);

  // internal AXI4-Lite link
  logic [`BR_ADDR_W-1:0]         awaddr, araddr;
  bedrock_pkg::axi_prot_e        awprot, arprot;
  logic                          awvalid, awready, arvalid, arready;
  logic [`BR_AXIL_DATA_W-1:0]    wdata, rdata;
  logic [`BR_AXIL_DATA_W/8-1:0]  wstrb;
  logic                          wvalid, wready;
  bedrock_pkg::axi_resp_e        bresp, rresp;
  logic                          bvalid, bready, rvalid, rready;

  burst_to_axil bridge_i (
    .clk_i                      (clk_i),
    .reset_i                    (reset_i),
    .io_cmd_header_i            (io_cmd_header_i),
    .io_cmd_header_v_i          (io_cmd_header_v_i),
    .io_cmd_has_data_i          (io_cmd_has_data_i),
    .io_cmd_header_ready_and_o  (io_cmd_header_ready_and_o),
    .io_cmd_data_i              (io_cmd_data_i),
    .io_cmd_data_v_i            (io_cmd_data_v_i),
    .io_cmd_last_i              (io_cmd_last_i),
    .io_cmd_data_ready_and_o    (io_cmd_data_ready_and_o),
    .io_resp_header_o           (io_resp_header_o),
    .io_resp_header_v_o         (io_resp_header_v_o),
    .io_resp_has_data_o         (io_resp_has_data_o),
    .io_resp_header_ready_and_i (io_resp_header_ready_and_i),
    .io_resp_data_o             (io_resp_data_o),
    .io_resp_data_v_o           (io_resp_data_v_o),
    .io_resp_last_o             (io_resp_last_o),
    .io_resp_data_ready_and_i   (io_resp_data_ready_and_i),
    .m_axil_awaddr_o            (awaddr),
    .m_axil_awprot_o            (awprot),
    .m_axil_awvalid_o           (awvalid),
    .m_axil_awready_i           (awready),
    .m_axil_wdata_o             (wdata),
    .m_axil_wstrb_o             (wstrb),
    .m_axil_wvalid_o            (wvalid),
    .m_axil_wready_i            (wready),
    .m_axil_bresp_i             (bresp),
    .m_axil_bvalid_i            (bvalid),
    .m_axil_bready_o            (bready),
    .m_axil_araddr_o            (araddr),
    .m_axil_arprot_o            (arprot),
    .m_axil_arvalid_o           (arvalid),
    .m_axil_arready_i           (arready),
    .m_axil_rdata_i             (rdata),
    .m_axil_rresp_i             (rresp),
    .m_axil_rvalid_i            (rvalid),
    .m_axil_rready_o            (rready)
  );

  axil_reg_target target_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awprot_i  (awprot),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arprot_i  (arprot),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator, verdict taken from the simulation log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --assert --timing \
  --top-module tb_io_axil_top \
  -Mdir "$build_dir" \
  -o sim_tb \
  -f io_axil_top.f > "$build_log" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$build_log"
  echo "build failed with status $status"
  exit 1
fi

"./$build_dir/sim_tb" > "$sim_log" 2>&1
status=$?
cat "$sim_log"

if grep -q "SIMULATION FAILED" "$sim_log"; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
if grep -q "SIMULATION PASSED" "$sim_log"; then
  exit 0
fi
echo "no verdict found in $sim_log"
exit 1

/* tb_io_axil_top.sv */
// one command in flight at a time; inputs change 2 ns after the rising edge, outputs are sampled 8 ns after it
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defs.svh"

module tb_io_axil_top;

  localparam int num_random_lp = 300;
  localparam int timeout_lp    = 200;

  logic                            clk_i;
  logic                            reset_i;
  bedrock_pkg::mem_header_s        io_cmd_header_i;
  logic                            io_cmd_header_v_i;
  logic                            io_cmd_has_data_i;
  logic                            io_cmd_header_ready_and_o;
  logic [`BR_IO_DATA_W-1:0]        io_cmd_data_i;
  logic                            io_cmd_data_v_i;
  logic                            io_cmd_last_i;
  logic                            io_cmd_data_ready_and_o;
  bedrock_pkg::mem_header_s        io_resp_header_o;
  logic                            io_resp_header_v_o;
  logic                            io_resp_has_data_o;
  logic                            io_resp_header_ready_and_i;
  logic [`BR_IO_DATA_W-1:0]        io_resp_data_o;
  logic                            io_resp_data_v_o;
  logic                            io_resp_last_o;
  logic                            io_resp_data_ready_and_i;

  logic [31:0]                     rng_state;
  // register file as the target should hold it
  logic [`BR_AXIL_DATA_W-1:0]      model [`BR_REG_COUNT];

  io_axil_top io_axil_top_i (
    .clk_i                      (clk_i),
    .reset_i                    (reset_i),
    .io_cmd_header_i            (io_cmd_header_i),
    .io_cmd_header_v_i          (io_cmd_header_v_i),
    .io_cmd_has_data_i          (io_cmd_has_data_i),
    .io_cmd_header_ready_and_o  (io_cmd_header_ready_and_o),
    .io_cmd_data_i              (io_cmd_data_i),
    .io_cmd_data_v_i            (io_cmd_data_v_i),
    .io_cmd_last_i              (io_cmd_last_i),
    .io_cmd_data_ready_and_o    (io_cmd_data_ready_and_o),
    .io_resp_header_o           (io_resp_header_o),
    .io_resp_header_v_o         (io_resp_header_v_o),
    .io_resp_has_data_o         (io_resp_has_data_o),
    .io_resp_header_ready_and_i (io_resp_header_ready_and_i),
    .io_resp_data_o             (io_resp_data_o),
    .io_resp_data_v_o           (io_resp_data_v_o),
    .io_resp_last_o             (io_resp_last_o),
    .io_resp_data_ready_and_i   (io_resp_data_ready_and_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic fail_with(input string what);
    $display("Error at %0t ns: %s", $time, what);
    abort_run();
  endtask

  // requester copies the field into every lane
  function automatic logic [63:0] replicate_write(input logic [31:0] value,
                                                  input bedrock_pkg::msg_size_e size);
    case (size)
      bedrock_pkg::e_size_1: return {8{value[7:0]}};
      bedrock_pkg::e_size_2: return {4{value[15:0]}};
      default:               return {2{value}};
    endcase
  endfunction

  function automatic logic [63:0] expected_read(input logic [31:0] addr,
                                                input bedrock_pkg::msg_size_e size);
    logic [31:0] field;
    field = model[addr[5:2]] >> (8 * addr[1:0]);
    case (size)
      bedrock_pkg::e_size_1: return {8{field[7:0]}};
      bedrock_pkg::e_size_2: return {4{field[15:0]}};
      default:               return {2{field}};
    endcase
  endfunction

  // only the addressed bytes change, bits 5:2 pick the register
  task automatic apply_write(input logic [31:0] addr, input bedrock_pkg::msg_size_e size,
                             input logic [31:0] data);
    int nbytes;
    nbytes = 1 << size;
    for (int b = 0; b < nbytes; b++) begin
      model[addr[5:2]][8*(addr[1:0] + b) +: 8] = data[8*(addr[1:0] + b) +: 8];
    end
  endtask

  task automatic run_command(input bedrock_pkg::mem_msg_e msg,
                             input bedrock_pkg::msg_size_e size,
                             input logic [31:0] addr, input logic [7:0] tag,
                             input logic [31:0] value);
    bedrock_pkg::mem_header_s hdr;
    logic        is_write;
    logic [63:0] wdata;
    logic [63:0] exp_data;
    logic [31:0] r;
    logic        hdr_sent, data_sent, resp_hdr_seen, resp_data_seen, done;
    logic        hdr_held, data_held;
    int          cycles;
    hdr.msg_type   = msg;
    hdr.size       = size;
    hdr.addr       = addr;
    hdr.tag        = tag;
    is_write       = msg inside {bedrock_pkg::e_mem_wr, bedrock_pkg::e_mem_uc_wr};
    wdata          = replicate_write(value, size);
    exp_data       = expected_read(addr, size);
    hdr_sent       = 1'b0;
    data_sent      = 1'b0;
    resp_hdr_seen  = 1'b0;
    resp_data_seen = 1'b0;
    hdr_held       = 1'b0;
    data_held      = 1'b0;
    done           = 1'b0;
    cycles         = 0;
    while (!done) begin
      @(posedge clk_i);
      #2;
      r = next_rand();
      io_cmd_header_i            = hdr;
      io_cmd_header_v_i          = !hdr_sent;
      io_cmd_has_data_i          = is_write;
      io_cmd_data_i              = wdata;
      io_cmd_data_v_i            = is_write && !data_sent;
      io_cmd_last_i              = 1'b1;
      io_resp_header_ready_and_i = r[0];
      io_resp_data_ready_and_i   = r[1];
      #6;
      if (hdr_held) begin
        assert (io_resp_header_v_o) else fail_with("response header valid dropped before ready");
      end
      if (io_resp_header_v_o) begin
        assert (hdr_sent && !resp_hdr_seen)
          else fail_with("response header with no command outstanding");
        assert (io_resp_header_o == hdr)
          else report_mismatch("io_resp_header_o", 64'(io_resp_header_o), 64'(hdr));
        assert (io_resp_has_data_o == !is_write)
          else report_mismatch("io_resp_has_data_o", 64'(io_resp_has_data_o), 64'(!is_write));
      end
      if (data_held) begin
        assert (io_resp_data_v_o) else fail_with("response data valid dropped before ready");
      end
      if (io_resp_data_v_o) begin
        assert (!is_write) else fail_with("write command returned a data beat");
        assert (resp_hdr_seen && !resp_data_seen)
          else fail_with("response data beat out of order or duplicated");
        assert (io_resp_data_o == exp_data)
          else report_mismatch("io_resp_data_o", io_resp_data_o, exp_data);
        assert (io_resp_last_o) else report_mismatch("io_resp_last_o", 64'(io_resp_last_o), 64'd1);
      end
      hdr_held  = io_resp_header_v_o && !io_resp_header_ready_and_i;
      data_held = io_resp_data_v_o && !io_resp_data_ready_and_i;
      if (io_resp_header_v_o && io_resp_header_ready_and_i) begin
        resp_hdr_seen = 1'b1;
      end
      if (io_resp_data_v_o && io_resp_data_ready_and_i) begin
        resp_data_seen = 1'b1;
      end
      // transfers land on the coming edge
      if (io_cmd_header_v_i && io_cmd_header_ready_and_o) begin
        hdr_sent = 1'b1;
      end
      if (io_cmd_data_v_i && io_cmd_data_ready_and_o) begin
        data_sent = 1'b1;
      end
      done = is_write ? resp_hdr_seen : resp_data_seen;
      cycles++;
      assert (done || cycles < timeout_lp) else fail_with("command timed out before its response");
    end
    if (is_write) begin
      apply_write(addr, size, wdata[31:0]);
    end
  endtask

  task automatic check_idle(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      #8;
      assert (!io_resp_header_v_o && !io_resp_data_v_o)
        else fail_with("response offered with no command outstanding");
    end
  endtask

  initial begin
    logic [31:0]            r;
    logic [31:0]            addr;
    logic [1:0]             sz;
    bedrock_pkg::mem_msg_e  msg;
    rng_state                  = 32'd85086;
    reset_i                    = 1'b1;
    io_cmd_header_i            = '0;
    io_cmd_header_v_i          = 1'b0;
    io_cmd_has_data_i          = 1'b0;
    io_cmd_data_i              = '0;
    io_cmd_data_v_i            = 1'b0;
    io_cmd_last_i              = 1'b0;
    io_resp_header_ready_and_i = 1'b0;
    io_resp_data_ready_and_i   = 1'b0;
    for (int i = 0; i < `BR_REG_COUNT; i++) begin
      model[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    #6;
    assert (io_cmd_header_ready_and_o && !io_cmd_data_ready_and_o
            && !io_resp_header_v_o && !io_resp_data_v_o)
      else fail_with("handshake outputs not idle after reset");

    // word round trip, then a byte through an alias 64 bytes up
    run_command(bedrock_pkg::e_mem_wr, bedrock_pkg::e_size_4, 32'h24, 8'h11, 32'hA5C3_1E77);
    run_command(bedrock_pkg::e_mem_rd, bedrock_pkg::e_size_4, 32'h24, 8'h12, 32'h0);
    run_command(bedrock_pkg::e_mem_uc_wr, bedrock_pkg::e_size_1, 32'h65, 8'h13, 32'h5A);
    run_command(bedrock_pkg::e_mem_rd, bedrock_pkg::e_size_4, 32'h24, 8'h14, 32'h0);
    run_command(bedrock_pkg::e_mem_uc_rd, bedrock_pkg::e_size_2, 32'hA6, 8'h15, 32'h0);
    run_command(bedrock_pkg::e_mem_rd, bedrock_pkg::e_size_1, 32'h25, 8'h16, 32'h0);

    for (int n = 0; n < num_random_lp; n++) begin
      r    = next_rand();
      msg  = bedrock_pkg::mem_msg_e'(r[1:0]);
      sz   = r[3:2] % 2'd3;
      addr = next_rand() & (32'hFFFF_FFFF << sz);
      run_command(msg, bedrock_pkg::msg_size_e'(sz), addr, r[15:8], next_rand());
    end
    check_idle(8);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
